// File: aspect_window.sv
`timescale 1ns/1ps

module aspect_window #(
	parameter int COORD_W = 12
) (
	input  logic               clk_vid,
	input  logic               i_rst_n,
	input  logic [COORD_W-1:0] i_arx,
	input  logic [COORD_W-1:0] i_ary,
	vid_cfg_if.calc            cfg,
	output logic [COORD_W-1:0] o_hmin,
	output logic [COORD_W-1:0] o_hmax,
	output logic [COORD_W-1:0] o_vmin,
	output logic [COORD_W-1:0] o_vmax
);

	localparam int STEP_W = $clog2(vid_geom_pkg::CALC_STEPS);
	localparam logic [STEP_W-1:0] STEP_TARGET = '0;
	localparam logic [STEP_W-1:0] STEP_CLIP   = STEP_W'(vid_geom_pkg::CALC_STEPS - 2);
	localparam logic [STEP_W-1:0] STEP_CENTRE = STEP_W'(vid_geom_pkg::CALC_STEPS - 1);

	logic [STEP_W-1:0]    step;
	logic [COORD_W-1:0]   use_w;
	logic [COORD_W-1:0]   use_h;
	logic [COORD_W-1:0]   rat_x;
	logic [COORD_W-1:0]   rat_y;
	logic                 use_full;
	logic [2*COORD_W-1:0] w_calc;
	logic [2*COORD_W-1:0] h_calc;
	logic [COORD_W-1:0]   vid_w;
	logic [COORD_W-1:0]   vid_h;
	logic [COORD_W-1:0]   h_off;
	logic [COORD_W-1:0]   v_off;

	// No ratio or free scale fills the usable area
	assign use_full = cfg.freescale || (rat_x == '0) || (rat_y == '0);

	// Window is centred in the full display
	assign h_off = (cfg.disp_width - vid_w) >> 1;
	assign v_off = (cfg.disp_height - vid_h) >> 1;

	////////////////////////////////////////
	// Usable size, ratio and target size
	////////////////////////////////////////

	always_ff @(posedge clk_vid) begin
		// Override applies only when nonzero and smaller
		use_h <= ((cfg.vset != '0) && (cfg.vset < cfg.disp_height)) ? cfg.vset
			: cfg.disp_height;
		use_w <= ((cfg.hset != '0) && (cfg.hset < cfg.disp_width)) ? cfg.hset
			: cfg.disp_width;

		if (i_ary == '0) begin
			// i_arx picks a custom ratio
			if (i_arx == COORD_W'(1)) begin
				rat_x <= cfg.arc1x;
				rat_y <= cfg.arc1y;
			end else if (i_arx == COORD_W'(2)) begin
				rat_x <= cfg.arc2x;
				rat_y <= cfg.arc2y;
			end else begin
				rat_x <= '0;
				rat_y <= '0;
			end
		end else begin
			rat_x <= i_arx;
			rat_y <= i_ary;
		end

		if (step == STEP_TARGET) begin
			if (use_full) begin
				w_calc <= (2*COORD_W)'(use_w);
				h_calc <= (2*COORD_W)'(use_h);
			end else begin
				w_calc <= (use_h * rat_x) / rat_y;
				h_calc <= (use_w * rat_y) / rat_x;
			end
		end

		// Clip to the usable area
		if (step == STEP_CLIP) begin
			vid_w <= (w_calc > use_w) ? use_w : w_calc[COORD_W-1:0];
			vid_h <= (h_calc > use_h) ? use_h : h_calc[COORD_W-1:0];
		end
	end

	////////////////////////////////////////
	// Step counter and window outputs
	////////////////////////////////////////

	always_ff @(posedge clk_vid or negedge i_rst_n) begin
		if (!i_rst_n) begin
			step   <= '0;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else begin
			step <= step + 1'b1;
			if (step == STEP_CENTRE) begin
				o_hmin <= h_off;
				o_hmax <= h_off + vid_w - 1'b1;
				o_vmin <= v_off;
				o_vmax <= v_off + vid_h - 1'b1;
			end
		end
	end

endmodule

// File: csync_gen.sv
`timescale 1ns/1ps

module csync_gen #(
	parameter int COORD_W = 12,
	parameter int CNT_W   = 16
) (
	input  logic clk_vid,
	input  logic i_rst_n,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	// Largest hsync pulse that fits the pulse register
	localparam logic [CNT_W-1:0] PULSE_MAX = CNT_W'({COORD_W{1'b1}});

	logic               hs_d;
	logic               hs_rise;
	logic               hs_fall;
	logic               hs_shaped;
	logic               vs_q;
	logic [CNT_W-1:0]   line_cnt;
	logic [CNT_W-1:0]   low_len;
	logic [COORD_W-1:0] pulse_len;

	assign hs_rise = i_hsync & ~hs_d;
	assign hs_fall = ~i_hsync & hs_d;

	assign o_csync = vs_q ^ hs_shaped;

	always_ff @(posedge clk_vid or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hs_d      <= 1'b0;
			hs_shaped <= 1'b0;
			vs_q      <= 1'b0;
			line_cnt  <= '0;
			low_len   <= '0;
			pulse_len <= '0;
		end else begin
			hs_d <= i_hsync;
			vs_q <= i_vsync;

			// The edge cycle counts as the first cycle of the line
			if (hs_rise) begin
				line_cnt <= CNT_W'(1);
				low_len  <= line_cnt - CNT_W'(pulse_len);
			end else if (~&line_cnt) begin
				line_cnt <= line_cnt + 1'b1;
			end

			if (hs_fall) begin
				pulse_len <= (line_cnt > PULSE_MAX) ? '1 : line_cnt[COORD_W-1:0];
			end

			// Inside vsync the pulse is stretched over the low phase
			if (!i_vsync) begin
				hs_shaped <= i_hsync;
			end else if (hs_rise) begin
				hs_shaped <= 1'b0;
			end else if (line_cnt == low_len) begin
				hs_shaped <= 1'b1;
			end
		end
	end

endmodule

// File: flist.f
vid_geom_pkg.sv
hps_cmd_pkg.sv
vid_cfg_if.sv
hps_cmd_decoder.sv
aspect_window.sv
sync_polarity_fix.sv
csync_gen.sv
vid_geom_top.sv
tb_vid_geom.sv

// File: hps_cmd_decoder.sv
`timescale 1ns/1ps

module hps_cmd_decoder #(
	parameter int COORD_W = 12
) (
	input  logic                  clk_vid,
	input  logic                  i_rst_n,
	input  logic                  i_io_uio,
	input  logic                  i_io_strobe,
	input  hps_cmd_pkg::io_word_u i_io_din,
	vid_cfg_if.dec                cfg
);

	logic                  uio_q;
	logic                  strobe_q;
	logic                  strobe_qq;
	hps_cmd_pkg::io_word_u din_q;
	logic                  word_stb;

	// Command state
	logic       has_cmd;
	logic [7:0] cmd;
	logic [3:0] cnt;

	////////////////////////////////////////
	// Strobe edge detection
	////////////////////////////////////////

	// Data word travels with the registered strobe
	always_ff @(posedge clk_vid) begin
		din_q <= i_io_din;
	end

	// One word per rising strobe edge while uio is high
	assign word_stb = uio_q & strobe_q & ~strobe_qq;

	////////////////////////////////////////
	// Command sequencing and registers
	////////////////////////////////////////

	always_ff @(posedge clk_vid or negedge i_rst_n) begin
		if (!i_rst_n) begin
			uio_q           <= 1'b0;
			strobe_q        <= 1'b0;
			strobe_qq       <= 1'b0;
			has_cmd         <= 1'b0;
			cmd             <= '0;
			cnt             <= '0;
			cfg.disp_width  <= vid_geom_pkg::DEF_WIDTH;
			cfg.disp_height <= vid_geom_pkg::DEF_HEIGHT;
			cfg.vset        <= '0;
			cfg.hset        <= '0;
			cfg.freescale   <= 1'b0;
			cfg.arc1x       <= '0;
			cfg.arc1y       <= '0;
			cfg.arc2x       <= '0;
			cfg.arc2y       <= '0;
		end else begin
			uio_q     <= i_io_uio;
			strobe_q  <= i_io_strobe;
			strobe_qq <= strobe_q;

			if (!uio_q) begin
				// Idle until the next opcode
				has_cmd <= 1'b0;
				cmd     <= '0;
				cnt     <= '0;
			end else if (word_stb) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= din_q.op.opcode;
					cnt     <= '0;
				end else begin
					// Saturate so late words never alias to low indices
					if (cnt != 4'hF) begin
						cnt <= cnt + 4'd1;
					end

					case (cmd)
						hps_cmd_pkg::CMD_VIDEO_TIMING: begin
							// Porch and sync words only advance the count
							if (cnt == 4'd0) begin
								cfg.disp_width <= COORD_W'(din_q.prm.value);
							end
							if (cnt == 4'd4) begin
								cfg.disp_height <= COORD_W'(din_q.prm.value);
							end
						end
						hps_cmd_pkg::CMD_VSET: begin
							cfg.vset <= COORD_W'(din_q.prm.value);
						end
						hps_cmd_pkg::CMD_HSET: begin
							cfg.freescale <= din_q.prm.flag;
							cfg.hset      <= COORD_W'(din_q.prm.value);
						end
						hps_cmd_pkg::CMD_ASPECT: begin
							case (cnt)
								4'd0: cfg.arc1x <= COORD_W'(din_q.prm.value);
								4'd1: cfg.arc1y <= COORD_W'(din_q.prm.value);
								4'd2: cfg.arc2x <= COORD_W'(din_q.prm.value);
								4'd3: cfg.arc2y <= COORD_W'(din_q.prm.value);
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: hps_cmd_pkg.sv
package hps_cmd_pkg;

	// Host word width
	localparam int IO_W = 16;

	////////////////////////////////////////
	// Command opcodes
	////////////////////////////////////////

	// Display size plus porch and sync widths
	localparam logic [7:0] CMD_VIDEO_TIMING = 8'h20;
	// Vertical size override
	localparam logic [7:0] CMD_VSET         = 8'h27;
	// Free-scale flag and horizontal override
	localparam logic [7:0] CMD_HSET         = 8'h37;
	// Two custom aspect ratios
	localparam logic [7:0] CMD_ASPECT       = 8'h3A;

	////////////////////////////////////////
	// Host word views
	////////////////////////////////////////

	// First word of a command
	typedef struct packed {
		logic [7:0] spare;
		logic [7:0] opcode;
	} io_op_t;

	// Every data word after the opcode
	typedef struct packed {
		logic        flag;
		logic [2:0]  spare;
		logic [11:0] value;
	} io_prm_t;

	typedef union packed {
		io_op_t  op;
		io_prm_t prm;
	} io_word_u;

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_vid_geom -f flist.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log 2>/dev/null && exit 0 || exit 1

// File: sync_polarity_fix.sv
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  logic clk_vid,
	input  logic i_rst_n,
	input  logic i_sync,
	output logic o_sync
);

	logic             s1;
	logic             s2;
	logic             pol;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;

	// Short phase always comes out high
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_vid or negedge i_rst_n) begin
		if (!i_rst_n) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			pol      <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Phase counter restarts on every transition
			if (s1 != s2) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end

			// Rising edge ends a low phase, falling edge a high phase
			if (s1 & ~s2) begin
				low_len <= cnt;
			end
			if (~s1 & s2) begin
				high_len <= cnt;
			end

			pol <= high_len > low_len;
		end
	end

endmodule

// File: tb_vid_geom.sv
`timescale 1ns/1ps

module tb_vid_geom;

	localparam int SETTLE   = 2 * vid_geom_pkg::CALC_STEPS + 2;
	localparam int WAIT_MAX = 4 * SETTLE;
	localparam int H_TOTAL  = 40;
	localparam int H_PULSE  = 6;
	localparam int V_TOTAL  = 12;
	localparam int V_PULSE  = 3;

	logic        clk_vid;
	logic        i_rst_n;
	logic        i_io_uio;
	logic        i_io_strobe;
	logic [15:0] i_io_din;
	logic [11:0] i_arx;
	logic [11:0] i_ary;
	logic        i_hs_raw;
	logic        i_vs_raw;
	logic        o_hs_fix;
	logic        o_vs_fix;
	logic        o_csync;
	logic [11:0] o_hmin;
	logic [11:0] o_hmax;
	logic [11:0] o_vmin;
	logic [11:0] o_vmax;
	logic [47:0] win_act;

	// Configuration as the host has written it
	int m_width;
	int m_height;
	int m_vset;
	int m_hset;
	int m_fs;
	int m_arc1x;
	int m_arc1y;
	int m_arc2x;
	int m_arc2y;

	int          n_pass;
	int          n_fail;
	integer      seed;
	logic [15:0] cmd_words [0:7];

	// Handshake with the compare process
	logic        chk_req;
	logic        chk_done;
	logic [47:0] chk_exp;
	string       chk_name;
	int          chk_cycles;

	assign win_act = {o_hmin, o_hmax, o_vmin, o_vmax};

	vid_geom_top dut0 (
		.clk_vid     (clk_vid),
		.i_rst_n     (i_rst_n),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.i_hs_raw    (i_hs_raw),
		.i_vs_raw    (i_vs_raw),
		.o_hs_fix    (o_hs_fix),
		.o_vs_fix    (o_vs_fix),
		.o_csync     (o_csync),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

	initial begin
		clk_vid = 1'b0;
		forever #10 clk_vid = ~clk_vid;
	end

	////////////////////////////////////////
	// Reference model and reporting
	////////////////////////////////////////

	// Centred window for the current configuration packed as hmin/hmax/vmin/vmax
	function automatic logic [47:0] window_ref(input int arx, input int ary);
		int uw;
		int uh;
		int rx;
		int ry;
		int tw;
		int th;
		int hmin;
		int vmin;
		uh = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		uw = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		rx = arx;
		ry = ary;
		if (ary == 0) begin
			rx = (arx == 1) ? m_arc1x : (arx == 2) ? m_arc2x : 0;
			ry = (arx == 1) ? m_arc1y : (arx == 2) ? m_arc2y : 0;
		end
		if (m_fs != 0 || rx == 0 || ry == 0) begin
			tw = uw;
			th = uh;
		end else begin
			tw = uh * rx / ry;
			th = uw * ry / rx;
		end
		if (tw > uw) tw = uw;
		if (th > uh) th = uh;
		hmin = (m_width - tw) / 2;
		vmin = (m_height - th) / 2;
		return {12'(hmin), 12'(hmin + tw - 1), 12'(vmin), 12'(vmin + th - 1)};
	endfunction

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			$display("ok     %s", name);
			n_pass = n_pass + 1;
		end else begin
			$display("failed %s with %0d mismatches", name, errs);
			n_fail = n_fail + 1;
		end
	endtask

	// Compares the window once the settling bound has passed
	always @(posedge clk_vid) begin
		if (!chk_req) begin
			chk_cycles <= 0;
			chk_done   <= 1'b0;
		end else if (!chk_done) begin
			if (chk_cycles < SETTLE) begin
				chk_cycles <= chk_cycles + 1;
			end else begin
				chk_done <= 1'b1;
				if (win_act !== chk_exp) begin
					$display("FAILED %s expected %0d %0d %0d %0d actual %0d %0d %0d %0d",
						chk_name, chk_exp[47:36], chk_exp[35:24], chk_exp[23:12],
						chk_exp[11:0], o_hmin, o_hmax, o_vmin, o_vmax);
					report_test(chk_name, 1);
				end else begin
					report_test(chk_name, 0);
				end
			end
		end
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic check_window(input string name);
		int t;
		chk_name = name;
		chk_exp  = window_ref(int'(i_arx), int'(i_ary));
		chk_req  = 1'b1;
		t = 0;
		while (!chk_done && t < WAIT_MAX) begin
			@(negedge clk_vid);
			t = t + 1;
		end
		if (!chk_done) begin
			$display("window check %s got no result from the compare process", name);
			n_fail = n_fail + 1;
		end
		chk_req = 1'b0;
		t = 0;
		while (chk_done && t < 8) begin
			@(negedge clk_vid);
			t = t + 1;
		end
	endtask

	// One host word with the strobe high for two cycles
	task automatic send_word(input logic [15:0] w);
		@(negedge clk_vid);
		i_io_din    = w;
		i_io_strobe = 1'b1;
		repeat (2) @(negedge clk_vid);
		i_io_strobe = 1'b0;
		repeat (1) @(negedge clk_vid);
	endtask

	task automatic send_cmd(input logic [7:0] op, input int n);
		int i;
		@(negedge clk_vid);
		i_io_uio = 1'b1;
		repeat (2) @(negedge clk_vid);
		send_word({8'h00, op});
		for (i = 0; i < n; i = i + 1) begin
			send_word(cmd_words[i]);
		end
		@(negedge clk_vid);
		i_io_uio = 1'b0;
		repeat (3) @(negedge clk_vid);
	endtask

	task automatic set_ratio(input int x, input int y);
		@(negedge clk_vid);
		i_arx = 12'(x);
		i_ary = 12'(y);
	endtask

	// Mode 0 only drives, mode 1 checks polarity, mode 2 checks composite sync
	task automatic run_frames(input logic act_low, input int frames, input int mode,
		input string name);
		int   f;
		int   vc;
		int   hc;
		int   errs;
		int   hi_cnt;
		int   prev_hc;
		logic hs_p;
		logic vs_p;
		logic prev_hs;
		logic prev_vs;
		logic prev_ok;
		errs    = 0;
		hi_cnt  = 0;
		prev_hc = 0;
		prev_hs = 1'b0;
		prev_vs = 1'b0;
		prev_ok = 1'b0;
		for (f = 0; f < frames; f = f + 1) begin
			for (vc = 0; vc < V_TOTAL; vc = vc + 1) begin
				for (hc = 0; hc < H_TOTAL; hc = hc + 1) begin
					@(negedge clk_vid);
					hs_p     = (hc < H_PULSE);
					vs_p     = (vc < V_PULSE);
					i_hs_raw = hs_p ^ act_low;
					i_vs_raw = vs_p ^ act_low;
					@(posedge clk_vid);
					if (mode == 1 && o_hs_fix !== hs_p) begin
						$display("FAILED %s expected hs %0b actual %0b", name, hs_p, o_hs_fix);
						errs = errs + 1;
					end
					if (mode == 1 && o_vs_fix !== vs_p) begin
						$display("FAILED %s expected vs %0b actual %0b", name, vs_p, o_vs_fix);
						errs = errs + 1;
					end
					if (mode == 2 && prev_ok && !prev_vs) begin
						hi_cnt = 0;
						if (o_csync !== prev_hs) begin
							$display("FAILED %s expected %0b actual %0b", name, prev_hs,
								o_csync);
							errs = errs + 1;
						end
					end else if (mode == 2 && prev_ok) begin
						// Count the high cycles of each vsync line
						if (o_csync === 1'b1) hi_cnt = hi_cnt + 1;
						if (prev_hc == H_TOTAL - 1) begin
							if (hi_cnt != H_TOTAL - H_PULSE) begin
								$display("FAILED %s expected %0d high cycles actual %0d", name,
									H_TOTAL - H_PULSE, hi_cnt);
								errs = errs + 1;
							end
							hi_cnt = 0;
						end
					end
					prev_hs = hs_p;
					prev_vs = vs_p;
					prev_hc = hc;
					prev_ok = 1'b1;
				end
			end
		end
		if (mode != 0) report_test(name, errs);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] rnd;
		int          i;
		seed        = 32'h7c3c9a86;
		n_pass      = 0;
		n_fail      = 0;
		chk_req     = 1'b0;
		chk_exp     = '0;
		chk_name    = "";
		i_rst_n     = 1'b0;
		i_io_uio    = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din    = '0;
		i_arx       = 12'd16;
		i_ary       = 12'd9;
		i_hs_raw    = 1'b0;
		i_vs_raw    = 1'b0;
		m_width     = int'(vid_geom_pkg::DEF_WIDTH);
		m_height    = int'(vid_geom_pkg::DEF_HEIGHT);
		m_vset      = 0;
		m_hset      = 0;
		m_fs        = 0;
		m_arc1x     = 0;
		m_arc1y     = 0;
		m_arc2x     = 0;
		m_arc2y     = 0;
		repeat (16) @(negedge clk_vid);
		i_rst_n = 1'b1;

		check_window("default_16x9");

		// Timing command with random porch words
		for (i = 0; i < 8; i = i + 1) begin
			rnd = $random(seed);
			cmd_words[i] = rnd[15:0];
		end
		cmd_words[0][11:0] = {1'b0, cmd_words[0][10:0]} | 12'h040;
		cmd_words[4][11:0] = {1'b0, cmd_words[4][10:0]} | 12'h040;
		m_width  = int'(cmd_words[0][11:0]);
		m_height = int'(cmd_words[4][11:0]);
		send_cmd(hps_cmd_pkg::CMD_VIDEO_TIMING, 8);
		check_window("video_timing");

		// Size overrides below and above the display
		m_vset = m_height / 2;
		cmd_words[0] = 16'(m_vset);
		send_cmd(hps_cmd_pkg::CMD_VSET, 1);
		check_window("vset_below");
		m_vset = m_height + 100;
		cmd_words[0] = 16'(m_vset);
		send_cmd(hps_cmd_pkg::CMD_VSET, 1);
		check_window("vset_above");
		m_hset = m_width / 2;
		cmd_words[0] = 16'(m_hset);
		send_cmd(hps_cmd_pkg::CMD_HSET, 1);
		check_window("hset_below");
		m_hset = m_width + 100;
		cmd_words[0] = 16'(m_hset);
		send_cmd(hps_cmd_pkg::CMD_HSET, 1);
		check_window("hset_above");
		m_hset = 0;
		m_fs   = 1;
		cmd_words[0] = 16'h8000;
		send_cmd(hps_cmd_pkg::CMD_HSET, 1);
		check_window("freescale");
		m_fs = 0;
		cmd_words[0] = 16'h0000;
		send_cmd(hps_cmd_pkg::CMD_HSET, 1);

		// Custom ratios picked through i_arx
		m_arc1x = 4;
		m_arc1y = 3;
		m_arc2x = 21;
		m_arc2y = 9;
		cmd_words[0] = 16'd4;
		cmd_words[1] = 16'd3;
		cmd_words[2] = 16'd21;
		cmd_words[3] = 16'd9;
		send_cmd(hps_cmd_pkg::CMD_ASPECT, 4);
		set_ratio(1, 0);
		check_window("custom_ratio_1");
		set_ratio(2, 0);
		check_window("custom_ratio_2");
		set_ratio(3, 0);
		check_window("custom_ratio_none");
		set_ratio(16, 9);

		// Sync polarity and composite sync for both input polarities
		run_frames(1'b1, 3, 0, "settle_low");
		run_frames(1'b1, 1, 1, "polarity_active_low");
		run_frames(1'b1, 1, 2, "csync_active_low");
		run_frames(1'b0, 3, 0, "settle_high");
		run_frames(1'b0, 1, 1, "polarity_active_high");
		run_frames(1'b0, 1, 2, "csync_active_high");

		$display("Summary: %0d tests ok, %0d tests failing", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: vid_cfg_if.sv
`timescale 1ns/1ps

interface vid_cfg_if #(
	parameter int COORD_W = 12
) ();

	// Display size from the timing command
	logic [COORD_W-1:0] disp_width;
	logic [COORD_W-1:0] disp_height;

	// Size overrides where zero means unused
	logic [COORD_W-1:0] vset;
	logic [COORD_W-1:0] hset;
	logic               freescale;

	// Custom aspect ratios that i_arx picks when i_ary is zero
	logic [COORD_W-1:0] arc1x;
	logic [COORD_W-1:0] arc1y;
	logic [COORD_W-1:0] arc2x;
	logic [COORD_W-1:0] arc2y;

	// Written by the command decoder
	modport dec (
		output disp_width,
		output disp_height,
		output vset,
		output hset,
		output freescale,
		output arc1x,
		output arc1y,
		output arc2x,
		output arc2y
	);

	// Read by the window calculator
	modport calc (
		input disp_width,
		input disp_height,
		input vset,
		input hset,
		input freescale,
		input arc1x,
		input arc1y,
		input arc2x,
		input arc2y
	);

endinterface

// File: vid_geom_pkg.sv
package vid_geom_pkg;

	////////////////////////////////////////
	// Coordinate format
	////////////////////////////////////////

	// Width of every coordinate and size
	localparam int COORD_W = 12;

	////////////////////////////////////////
	// Display defaults
	////////////////////////////////////////

	// 1920x1080 until the host sends a timing command
	localparam logic [COORD_W-1:0] DEF_WIDTH  = 12'd1920;
	localparam logic [COORD_W-1:0] DEF_HEIGHT = 12'd1080;

	////////////////////////////////////////
	// Window calculator
	////////////////////////////////////////

	// One full pass of the calculator, in clocks
	localparam int CALC_STEPS = 8;

endpackage

// File: vid_geom_top.sv
`timescale 1ns/1ps

module vid_geom_top #(
	parameter int COORD_W = vid_geom_pkg::COORD_W,
	parameter int CNT_W   = 16
) (
	input  logic                         clk_vid,
	input  logic                         i_rst_n,

	// Host command port
	input  logic                         i_io_uio,
	input  logic                         i_io_strobe,
	input  logic [hps_cmd_pkg::IO_W-1:0] i_io_din,

	// Aspect ratio from the core
	input  logic [COORD_W-1:0]           i_arx,
	input  logic [COORD_W-1:0]           i_ary,

	// Raw and normalised syncs
	input  logic                         i_hs_raw,
	input  logic                         i_vs_raw,
	output logic                         o_hs_fix,
	output logic                         o_vs_fix,
	output logic                         o_csync,

	// Output window
	output logic [COORD_W-1:0]           o_hmin,
	output logic [COORD_W-1:0]           o_hmax,
	output logic [COORD_W-1:0]           o_vmin,
	output logic [COORD_W-1:0]           o_vmax
);

	vid_cfg_if #(.COORD_W(COORD_W)) cfg_bus ();

	////////////////////////////////////////
	// Geometry path
	////////////////////////////////////////

	hps_cmd_decoder #(.COORD_W(COORD_W)) dec0 (
		.clk_vid     (clk_vid),
		.i_rst_n     (i_rst_n),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.cfg         (cfg_bus)
	);

	aspect_window #(.COORD_W(COORD_W)) win0 (
		.clk_vid (clk_vid),
		.i_rst_n (i_rst_n),
		.i_arx   (i_arx),
		.i_ary   (i_ary),
		.cfg     (cfg_bus),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

	////////////////////////////////////////
	// Sync path
	////////////////////////////////////////

	sync_polarity_fix #(.CNT_W(CNT_W)) sync_h (
		.clk_vid (clk_vid),
		.i_rst_n (i_rst_n),
		.i_sync  (i_hs_raw),
		.o_sync  (o_hs_fix)
	);

	sync_polarity_fix #(.CNT_W(CNT_W)) sync_v (
		.clk_vid (clk_vid),
		.i_rst_n (i_rst_n),
		.i_sync  (i_vs_raw),
		.o_sync  (o_vs_fix)
	);

	// Composite sync from the normalised pair
	csync_gen #(.COORD_W(COORD_W), .CNT_W(CNT_W)) csync0 (
		.clk_vid (clk_vid),
		.i_rst_n (i_rst_n),
		.i_hsync (o_hs_fix),
		.i_vsync (o_vs_fix),
		.o_csync (o_csync)
	);

endmodule
